/* cam_pkg.sv */
package cam_pkg;

    // camera raster as delivered on the parallel bus
    localparam int cam_width = 1280;
    localparam int cam_height = 720;

    // down-sample by 1 << decim_shift in both directions
    localparam int decim_shift = 2;

    // stored image after down-sampling
    localparam int fb_width = cam_width >> decim_shift;
    localparam int fb_height = cam_height >> decim_shift;
    localparam int fb_depth = fb_width * fb_height;
    localparam int fb_addr_bits = $clog2(fb_depth);

    // column and row counter widths
    localparam int hcount_bits = $clog2(cam_width);
    localparam int vcount_bits = $clog2(cam_height);

    // rgb565, one memory word per pixel
    typedef logic [15:0] pixel_t;

    // raw camera pins, before the synchronizer
    typedef struct packed {
        logic [7:0] data;
        logic       pclk;
        logic       hsync;
        logic       vsync;
    } cam_bus_t;

    // assembler output, each flag is a single-cycle pulse
    typedef struct packed {
        logic   pixel_done;
        logic   line_end;
        logic   frame_end;
        pixel_t pixel;
    } cam_event_t;

    // position of the pixel the next pixel_done completes
    typedef struct packed {
        logic [hcount_bits-1:0] hcount;
        logic [vcount_bits-1:0] vcount;
    } cam_coord_t;

    // one registered frame-buffer write
    typedef struct packed {
        logic                    en;
        logic [fb_addr_bits-1:0] addr;
        pixel_t                  data;
    } fb_write_t;

endpackage

/* wb_pkg.sv */
package wb_pkg;

    // the host port addresses frame-buffer words directly
    localparam int wb_adr_bits = cam_pkg::fb_addr_bits;

    // one pixel per bus word
    localparam int wb_dat_bits = 16;

    // master to slave, classic cycle without bursts or byte selects
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [wb_adr_bits-1:0] adr;
        logic [wb_dat_bits-1:0] dat;
    } wb_req_t;

    // slave to master
    // dat is only meaningful in the ack cycle of a read
    typedef struct packed {
        logic                   ack;
        logic [wb_dat_bits-1:0] dat;
    } wb_rsp_t;

endpackage

/* cam_pixel_assembler.sv */
`timescale 1ns/1ps

module cam_pixel_assembler (
    input  logic                clk_camera,
    input  logic                recent_reset,
    input  cam_pkg::cam_bus_t   cam_bus,
    output cam_pkg::cam_event_t cam_event
);
    import cam_pkg::*;
    import wb_pkg::*;

    typedef enum logic {
        await_high,
        await_low
    } asm_state_t;

    // two-stage synchronizer, sync_q2 is the sampled bus
    cam_bus_t   sync_q1;
    cam_bus_t   sync_q2;
    // previous sampled control pins for edge detection
    logic       prev_pclk;
    logic       prev_hsync;
    logic       prev_vsync;
    logic       pclk_rise;
    logic       hsync_fall;
    logic       vsync_fall;
    logic       byte_valid;
    asm_state_t state;
    logic [7:0] high_byte;
    logic       pixel_done_q;
    logic       line_end_q;
    logic       frame_end_q;
    pixel_t     pixel_q;

    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            sync_q1    <= '0;
            sync_q2    <= '0;
            prev_pclk  <= 1'b0;
            prev_hsync <= 1'b0;
            prev_vsync <= 1'b0;
        end else begin
            sync_q1    <= cam_bus;
            sync_q2    <= sync_q1;
            prev_pclk  <= sync_q2.pclk;
            prev_hsync <= sync_q2.hsync;
            prev_vsync <= sync_q2.vsync;
        end
    end

    assign pclk_rise  = sync_q2.pclk && !prev_pclk;
    assign hsync_fall = prev_hsync && !sync_q2.hsync;
    assign vsync_fall = prev_vsync && !sync_q2.vsync;
    // bytes only count inside an active line of an active frame
    assign byte_valid = pclk_rise && sync_q2.hsync && sync_q2.vsync;

    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            state        <= await_high;
            pixel_done_q <= 1'b0;
            line_end_q   <= 1'b0;
            frame_end_q  <= 1'b0;
        end else begin
            pixel_done_q <= 1'b0;
            line_end_q   <= hsync_fall;
            frame_end_q  <= vsync_fall;
            if (hsync_fall || vsync_fall) begin
                // a half pixel left at the end of a line is dropped
                state <= await_high;
            end else if (byte_valid) begin
                if (state == await_high) begin
                    state <= await_low;
                end else begin
                    state        <= await_high;
                    pixel_done_q <= 1'b1;
                end
            end
        end
    end

    // pixel payload, qualified by pixel_done
    always_ff @(posedge clk_camera) begin
        if (byte_valid && state == await_high) begin
            high_byte <= sync_q2.data;
        end
        if (byte_valid && state == await_low) begin
            // high byte arrives first on the bus
            pixel_q <= {high_byte, sync_q2.data};
        end
    end

    assign cam_event = '{
        pixel_done: pixel_done_q,
        line_end:   line_end_q,
        frame_end:  frame_end_q,
        pixel:      pixel_q
    };

endmodule

/* cam_position_counter.sv */
`timescale 1ns/1ps

module cam_position_counter (
    input  logic                clk_camera,
    input  logic                recent_reset,
    input  cam_pkg::cam_event_t cam_event,
    output cam_pkg::cam_coord_t coord
);
    import cam_pkg::*;
    import wb_pkg::*;

    logic [hcount_bits-1:0] hcount;
    logic [vcount_bits-1:0] vcount;
    logic                   h_last;
    logic                   v_last;

    // saturation points, so an overlong line or frame
    // stays on the last column or row and never wraps to zero
    assign h_last = (hcount == hcount_bits'(cam_width - 1));
    assign v_last = (vcount == vcount_bits'(cam_height - 1));

    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            hcount <= '0;
            vcount <= '0;
        end else if (cam_event.frame_end) begin
            // vsync low, next pixel is the top left corner
            hcount <= '0;
            vcount <= '0;
        end else if (cam_event.line_end) begin
            hcount <= '0;
            if (!v_last) begin
                vcount <= vcount + 1'b1;
            end
        end else if (cam_event.pixel_done) begin
            if (!h_last) begin
                hcount <= hcount + 1'b1;
            end
        end
    end

    // still the current pixel's position in the pixel_done cycle
    assign coord = '{
        hcount: hcount,
        vcount: vcount
    };

endmodule

/* cam_decimator.sv */
`timescale 1ns/1ps

module cam_decimator (
    input  logic                clk_camera,
    input  logic                recent_reset,
    input  cam_pkg::cam_event_t cam_event,
    input  cam_pkg::cam_coord_t coord,
    output cam_pkg::fb_write_t  fb_write
);
    import cam_pkg::*;
    import wb_pkg::*;

    logic                    keep;
    logic [fb_addr_bits-1:0] col;
    logic [fb_addr_bits-1:0] row;
    logic [fb_addr_bits-1:0] addr_next;
    logic                    en_q;
    logic [fb_addr_bits-1:0] addr_q;
    pixel_t                  data_q;

    // one pixel in sixteen, low bits of both counters zero
    assign keep = cam_event.pixel_done
               && (coord.hcount[decim_shift-1:0] == '0)
               && (coord.vcount[decim_shift-1:0] == '0);

    // frame-buffer coordinates after down-sampling
    assign col = fb_addr_bits'(coord.hcount >> decim_shift);
    assign row = fb_addr_bits'(coord.vcount >> decim_shift);

    // row-major, fb_width words per stored row
    assign addr_next = col + row * fb_addr_bits'(fb_width);

    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            en_q <= 1'b0;
        end else begin
            en_q <= keep;
        end
    end

    always_ff @(posedge clk_camera) begin
        if (keep) begin
            addr_q <= addr_next;
            data_q <= cam_event.pixel;
        end
    end

    assign fb_write = '{
        en:   en_q,
        addr: addr_q,
        data: data_q
    };

endmodule

/* frame_buffer.sv */
`timescale 1ns/1ps

module frame_buffer (
    input  logic               clk_camera,
    input  logic               recent_reset,
    input  cam_pkg::fb_write_t fb_write,
    input  wb_pkg::wb_req_t    host_req,
    output wb_pkg::wb_rsp_t    host_rsp
);
    import cam_pkg::*;
    import wb_pkg::*;

    pixel_t                 mem [fb_depth];
    // set once a request has been acked, cleared when stb drops
    logic                   served;
    logic                   ack_q;
    logic [wb_dat_bits-1:0] rdat_q;
    logic                   host_pending;
    logic                   host_in_range;
    logic                   cam_collides;
    logic                   host_store;

    // a new classic cycle that has not been answered yet
    assign host_pending = host_req.cyc && host_req.stb && !served;

    // the bus can address past the end of the stored image
    assign host_in_range = (host_req.adr < wb_adr_bits'(fb_depth));

    // camera write to the same word in the same cycle wins
    assign cam_collides = fb_write.en && (fb_write.addr == host_req.adr);

    assign host_store = host_pending
                     && host_req.we
                     && host_in_range
                     && !cam_collides;

    // both write ports, camera address is always in range
    always_ff @(posedge clk_camera) begin
        if (fb_write.en) begin
            mem[fb_write.addr] <= fb_write.data;
        end
        if (host_store) begin
            mem[host_req.adr] <= host_req.dat;
        end
    end

    // read data lines up with ack
    always_ff @(posedge clk_camera) begin
        if (host_pending && !host_req.we) begin
            rdat_q <= host_in_range ? mem[host_req.adr] : '0;
        end
    end

    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            ack_q  <= 1'b0;
            served <= 1'b0;
        end else begin
            // single-cycle ack, one cycle after the request is sampled
            ack_q  <= host_pending;
            served <= host_req.cyc && host_req.stb;
        end
    end

    assign host_rsp = '{
        ack: ack_q,
        dat: rdat_q
    };

endmodule

/* camera_capture_top.sv */
`timescale 1ns/1ps

module camera_capture_top (
    input  logic              clk_camera,
    input  logic              recent_reset,
    input  cam_pkg::cam_bus_t cam_bus,
    input  wb_pkg::wb_req_t   host_req,
    output wb_pkg::wb_rsp_t   host_rsp
);
    import cam_pkg::*;
    import wb_pkg::*;

    // assembler events, fanned out to counter and decimator
    cam_event_t cam_event;
    cam_coord_t coord;
    fb_write_t  fb_write;

    // synchronizer, edge detect and byte pairing
    cam_pixel_assembler cam_pixel_assembler_inst (
        .clk_camera   (clk_camera),
        .recent_reset (recent_reset),
        .cam_bus      (cam_bus),
        .cam_event    (cam_event)
    );

    cam_position_counter cam_position_counter_inst (
        .clk_camera   (clk_camera),
        .recent_reset (recent_reset),
        .cam_event    (cam_event),
        .coord        (coord)
    );

    // keeps every fourth column of every fourth row
    cam_decimator cam_decimator_inst (
        .clk_camera   (clk_camera),
        .recent_reset (recent_reset),
        .cam_event    (cam_event),
        .coord        (coord),
        .fb_write     (fb_write)
    );

    // 320 by 180 store, host side on wishbone
    frame_buffer frame_buffer_inst (
        .clk_camera   (clk_camera),
        .recent_reset (recent_reset),
        .fb_write     (fb_write),
        .host_req     (host_req),
        .host_rsp     (host_rsp)
    );

endmodule

/* camera_capture_sva.sv */
`timescale 1ns/1ps

module camera_capture_sva (
    input logic               clk_camera,
    input logic               recent_reset,
    input cam_pkg::fb_write_t fb_write,
    input wb_pkg::wb_req_t    host_req,
    input wb_pkg::wb_rsp_t    host_rsp
);
    import cam_pkg::*;
    import wb_pkg::*;

    // classic slave answers each request with a single ack pulse
    ack_one_cycle: assert property (@(posedge clk_camera) disable iff (recent_reset)
        host_rsp.ack |=> !host_rsp.ack)
        else $error("wishbone ack held longer than one cycle");

    // no ack without a request in the cycle before
    ack_after_request: assert property (@(posedge clk_camera) disable iff (recent_reset)
        host_rsp.ack |-> $past(host_req.cyc && host_req.stb))
        else $error("wishbone ack without cyc and stb");

    // camera write strobe stays low while in reset
    no_write_in_reset: assert property (@(posedge clk_camera)
        recent_reset |=> !fb_write.en)
        else $error("frame buffer write during reset");

endmodule

bind frame_buffer camera_capture_sva camera_capture_sva_inst (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .fb_write     (fb_write),
    .host_req     (host_req),
    .host_rsp     (host_rsp)
);

/* tb_camera_capture.sv */
`timescale 1ns/1ps

module tb_camera_capture;
    import cam_pkg::*;
    import wb_pkg::*;

    // short frame, full lines but only 16 rows
    localparam int line_pixels = 1280;
    localparam int frame_rows = 16;
    // 16 camera rows fill stored rows 0 to 3
    localparam int stored_cols = 320;
    localparam int model_words = stored_cols * 4;
    localparam int ack_timeout = 16;

    logic        clk_camera;
    logic        recent_reset;
    cam_bus_t    cam_bus;
    wb_req_t     host_req;
    wb_rsp_t     host_rsp;
    logic [31:0] rng;
    // expected word per stored address
    logic [15:0] model [model_words];
    int          errors;
    int          checks;
    int          tests;
    int          test_start;
    int          i;
    int          addr_sel;
    logic [15:0] rd;
    logic [15:0] wdata;

    camera_capture_top camera_capture_top_inst (
        .clk_camera   (clk_camera),
        .recent_reset (recent_reset),
        .cam_bus      (cam_bus),
        .host_req     (host_req),
        .host_rsp     (host_rsp)
    );

    initial begin
        clk_camera = 1'b0;
        forever #5 clk_camera = ~clk_camera;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $finish;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s %s", tests, name, (errors == test_start) ? "passed" : "failed");
        test_start = errors;
    endtask

    // one classic cycle, cyc and stb held until ack
    task automatic wb_cycle(input logic we, input logic [15:0] adr, input logic [15:0] dat,
                            output logic [15:0] rdat);
        int n;
        host_req.cyc = 1'b1;
        host_req.stb = 1'b1;
        host_req.we  = we;
        host_req.adr = adr;
        host_req.dat = dat;
        for (n = 0; n < ack_timeout; n++) begin
            @(negedge clk_camera);
            if (host_rsp.ack) break;
        end
        if (!host_rsp.ack) begin
            abort_run($sformatf("no wishbone ack for address %h", adr));
        end else begin
            rdat = host_rsp.dat;
            host_req.cyc = 1'b0;
            host_req.stb = 1'b0;
            host_req.we  = 1'b0;
            // stb low across one edge so the slave can take the next request
            @(negedge clk_camera);
        end
    endtask

    task automatic wb_read(input logic [15:0] adr, output logic [15:0] rdat);
        wb_cycle(1'b0, adr, 16'd0, rdat);
    endtask

    task automatic wb_write(input logic [15:0] adr, input logic [15:0] dat);
        logic [15:0] unused;
        wb_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic check_words(input string name, input int first, input int last);
        int a;
        logic [15:0] d;
        for (a = first; a <= last; a++) begin
            wb_read(16'(a), d);
            check(name, model[a], d);
        end
    endtask

    task automatic cam_idle(input int n);
        repeat (n) @(negedge clk_camera);
    endtask

    // pclk runs at a quarter of clk_camera, data set while pclk is low
    task automatic cam_byte(input logic [7:0] b, input bit gaps);
        cam_bus.data = b;
        cam_bus.pclk = 1'b0;
        cam_idle(2);
        if (gaps) begin
            // pclk stalls low for a few cycles
            rng = xorshift32(rng);
            cam_idle(int'(rng[2:0]));
        end
        cam_bus.pclk = 1'b1;
        cam_idle(2);
    endtask

    task automatic send_line(input int row, input bit gaps, input bit half);
        int col;
        logic [15:0] pix;
        cam_bus.hsync = 1'b1;
        cam_idle(4);
        for (col = 0; col < line_pixels; col++) begin
            rng = xorshift32(rng);
            pix = rng[31:16];
            // high byte first on the bus
            cam_byte(pix[15:8], gaps);
            cam_byte(pix[7:0], gaps);
            if (col % 4 == 0 && row % 4 == 0) model[col / 4 + stored_cols * (row / 4)] = pix;
        end
        // lone byte that the falling hsync has to throw away
        if (half) cam_byte(rng[7:0], gaps);
        cam_bus.pclk = 1'b0;
        cam_idle(2);
        cam_bus.hsync = 1'b0;
        cam_idle(gaps ? 4 + int'(rng[3:0]) : 6);
    endtask

    task automatic send_frame(input bit gaps, input int half_row);
        int row;
        cam_bus.vsync = 1'b1;
        cam_idle(6);
        for (row = 0; row < frame_rows; row++) send_line(row, gaps, row == half_row);
        cam_bus.vsync = 1'b0;
        // pipeline flush before the host looks
        cam_idle(12);
    endtask

    initial begin
        rng = 32'ha7367ee5;
        errors = 0;
        checks = 0;
        tests = 0;
        test_start = 0;
        recent_reset = 1'b1;
        cam_bus = '0;
        host_req = '0;
        repeat (8) @(negedge clk_camera);
        recent_reset = 1'b0;
        cam_idle(4);

        // memory still empty, only the handshake matters
        for (i = 0; i < 6; i++) begin
            rng = xorshift32(rng);
            wb_read(16'(rng % 32'd57600), rd);
            check("reset_read_ack_drop", 16'd0, {15'd0, host_rsp.ack});
        end
        end_test("reset_read_ack");

        // half pixel left on row 3
        send_frame(1'b0, 3);
        check_words("first_frame", 0, model_words - 1);
        end_test("first_frame");

        // stored row 1 comes from camera row 4, right after the half line
        check_words("half_pixel_line", stored_cols, 2 * stored_cols - 1);
        end_test("half_pixel_line");

        send_frame(1'b0, -1);
        check_words("second_frame", 0, model_words - 1);
        end_test("second_frame");

        rng = xorshift32(rng);
        addr_sel = int'(rng % 32'(model_words));
        wdata = rng[31:16];
        wb_write(16'(addr_sel), wdata);
        model[addr_sel] = wdata;
        wb_read(16'(addr_sel), rd);
        check("host_write_read", model[addr_sel], rd);
        end_test("host_write_read");

        send_frame(1'b1, 7);
        check_words("idle_gaps", 0, model_words - 1);
        end_test("idle_gaps");

        $display("tests %0d checks %0d errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
cam_pkg.sv
wb_pkg.sv
cam_pixel_assembler.sv
cam_position_counter.sv
cam_decimator.sv
frame_buffer.sv
camera_capture_top.sv
camera_capture_sva.sv
tb_camera_capture.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_camera_capture
FILELIST  = vlog.f
PASS_MSG  = Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
